// ==== build.f ====
+incdir+common
common/rv32m_pkg.sv
multiplier/shift_add_multiplier.sv
divider/radix2_divider.sv
hdl/rv32m_execute.sv
hdl/rv32m_unit.sv
tb/rv32m_props.sv
tb/rv32m_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the RV32M testbench with Verilator.
# The verdict comes from the pass line in the simulation log.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -j 0 -f build.f --top-module rv32m_tb -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench prints its verdict
"./$OBJ_DIR/Vrv32m_tb" +verilator+error+limit+1000000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test OK" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// ==== tb/rv32m_tb.sv ====
/* RV32M unit testbench
   directed multiply, divide, special-case, reuse and slow-release tests
   against a 64-bit reference model of the RISC-V M rules */
`timescale 1ns/1ps
`default_nettype none

`include "rv32m_params.svh"

module rv32m_tb
  import rv32m_pkg::*;
;

  localparam int W            = `RV32M_WORD;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int RAND_PAIRS   = 40;

  // transaction counts per test, used to size the watchdog
  localparam int MUL_TXNS     = 4 * (25 + RAND_PAIRS);
  localparam int DIV_TXNS     = 4 * (25 + RAND_PAIRS);
  localparam int SPECIAL_TXNS = 4 * 5 + 4;
  localparam int REUSE_TXNS   = 2 * 6;
  localparam int RELEASE_TXNS = 20;
  localparam int TOTAL_TXNS   = MUL_TXNS + DIV_TXNS + SPECIAL_TXNS + REUSE_TXNS + RELEASE_TXNS;
  localparam int WATCHDOG_NS  =
    (RESET_CYCLES + TOTAL_TXNS * (`RV32M_DIV_STEPS + 10)) * CLK_PERIOD;

  logic       CLK;
  logic       nRST;
  logic       req;
  logic [2:0] funct3;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       ack;
  word_t      result;

  logic [31:0] lfsr_state;
  int          pass_count;
  int          fail_count;

  // zero, one, minus one, most negative, most positive
  word_t corners [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                         32'h8000_0000, 32'h7fff_ffff};

  rv32m_unit uut (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .funct3   (funct3),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ack      (ack),
    .result   (result)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic word_t rand_bits(input int n);
    word_t v;
    logic  fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[W-2:0], fb};
    end
    return v;
  endfunction

  function automatic rv32m_op_u mul_op(input logic [1:0] kind);
    rv32m_op_u op;
    op.mul_view.div_sel = 1'b0;
    op.mul_view.kind    = kind;
    return op;
  endfunction

  function automatic rv32m_op_u div_op(input logic rem, input logic uns);
    rv32m_op_u op;
    op.div_view.div_sel     = 1'b1;
    op.div_view.rem_sel     = rem;
    op.div_view.is_unsigned = uns;
    return op;
  endfunction

  // reference model straight from the RV32M rules
  function automatic word_t expected_result(input rv32m_op_u op, input word_t a,
                                            input word_t b);
    logic [2*W-1:0] ax;
    logic [2*W-1:0] bx;
    logic [2*W-1:0] prod;
    logic           a_sgn;
    logic           b_sgn;
    logic           uns;
    longint         sa;
    longint         sb;
    word_t          q;
    word_t          r;
    if (!op.mul_view.div_sel) begin
      // MULHU both unsigned, MULHSU only rs1 signed
      a_sgn = (op.mul_view.kind != MUL_HUU);
      b_sgn = (op.mul_view.kind == MUL_LOW) || (op.mul_view.kind == MUL_HSS);
      ax    = a_sgn ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
      bx    = b_sgn ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
      prod  = ax * bx;
      return (op.mul_view.kind == MUL_LOW) ? prod[W-1:0] : prod[2*W-1:W];
    end
    uns = op.div_view.is_unsigned;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (!uns && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;
      r = '0;
    end else if (!uns) begin
      // truncating divide, remainder keeps the dividend sign
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      q  = word_t'(sa / sb);
      r  = word_t'(sa % sb);
    end else begin
      q = a / b;
      r = a % b;
    end
    return op.div_view.rem_sel ? r : q;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) pass_count++;
    else begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      fail_count++;
    end
  endtask

  // one four-phase transaction, req held for extra cycles after ack
  task automatic run_txn(input rv32m_op_u op, input word_t a, input word_t b,
                         input int hold);
    word_t exp;
    int    waited;
    exp      = expected_result(op, a, b);
    req      = 1'b1;
    funct3   = op;
    rs1_data = a;
    rs2_data = b;
    do begin
      @(negedge CLK);
    end while (!ack);
    check_word("result", exp, result);
    for (int i = 0; i < hold; i++) begin
      @(negedge CLK);
      check_word("result", exp, result);
      assert (ack) pass_count++;
      else begin
        $display("ack dropped at %0t while req was still high", $time);
        fail_count++;
      end
    end
    req    = 1'b0;
    waited = 0;
    while (ack && waited < 4) begin
      @(negedge CLK);
      waited++;
    end
    assert (!ack) pass_count++;
    else begin
      $display("ack stayed high at %0t after req was released", $time);
      fail_count++;
    end
  endtask

  task automatic report_test(input string name, input int start_fails);
    $display("%s finished, %0d checks failed", name, fail_count - start_fails);
  endtask

  task automatic test_mul_variants();
    int    start_fails;
    word_t a;
    word_t b;
    start_fails = fail_count;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_txn(mul_op(2'(k)), corners[i], corners[j], 0);
        end
      end
      for (int n = 0; n < RAND_PAIRS; n++) begin
        a = rand_bits(W);
        b = rand_bits(W);
        run_txn(mul_op(2'(k)), a, b, 0);
      end
    end
    report_test("mul variants", start_fails);
  endtask

  task automatic test_div_variants();
    int         start_fails;
    logic [1:0] kk;
    word_t      a;
    word_t      b;
    start_fails = fail_count;
    // DIV, DIVU, REM, REMU in funct3 order
    for (int k = 0; k < 4; k++) begin
      kk = 2'(k);
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_txn(div_op(kk[1], kk[0]), corners[i], corners[j], 0);
        end
      end
      for (int n = 0; n < RAND_PAIRS; n++) begin
        a = rand_bits(W);
        do begin
          b = rand_bits(W);
        end while (b == '0);
        run_txn(div_op(kk[1], kk[0]), a, b, 0);
      end
    end
    report_test("div variants", start_fails);
  endtask

  task automatic test_special_cases();
    int         start_fails;
    logic [1:0] kk;
    start_fails = fail_count;
    for (int k = 0; k < 4; k++) begin
      kk = 2'(k);
      // zero divisor on every corner dividend
      for (int i = 0; i < 5; i++) begin
        run_txn(div_op(kk[1], kk[0]), corners[i], 32'h0, 0);
      end
      // most negative over minus one
      run_txn(div_op(kk[1], kk[0]), 32'h8000_0000, 32'hffff_ffff, 0);
    end
    report_test("special cases", start_fails);
  endtask

  task automatic test_result_reuse();
    int    start_fails;
    word_t a;
    word_t b;
    start_fails = fail_count;
    for (int n = 0; n < 2; n++) begin
      a = rand_bits(W);
      b = rand_bits(W) | 32'h1;
      // high half then low half of one product
      run_txn(mul_op(MUL_HSS), a, b, 0);
      run_txn(mul_op(MUL_LOW), a, b, 0);
      run_txn(mul_op(MUL_LOW), a, b + 32'h1, 0);
      // quotient then remainder of one divide
      run_txn(div_op(1'b0, 1'b0), a, b, 0);
      run_txn(div_op(1'b1, 1'b0), a, b, 0);
      run_txn(div_op(1'b1, 1'b0), a ^ 32'h1, b, 0);
    end
    report_test("result reuse", start_fails);
  endtask

  task automatic test_slow_release();
    int        start_fails;
    word_t     sel;
    word_t     a;
    word_t     b;
    int        hold;
    rv32m_op_u op;
    start_fails = fail_count;
    for (int n = 0; n < RELEASE_TXNS; n++) begin
      sel  = rand_bits(3);
      op   = sel[2] ? div_op(sel[1], sel[0]) : mul_op(sel[1:0]);
      a    = rand_bits(W);
      b    = rand_bits(W);
      hold = int'(rand_bits(4));
      run_txn(op, a, b, hold);
    end
    report_test("slow release", start_fails);
  endtask

  initial begin
    CLK        = 1'b0;
    nRST       = 1'b0;
    req        = 1'b0;
    funct3     = '0;
    rs1_data   = '0;
    rs2_data   = '0;
    lfsr_state = 32'h4a23;
    pass_count = 0;
    fail_count = 0;
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    test_mul_variants();
    test_div_variants();
    test_special_cases();
    test_result_reuse();
    test_slow_release();
    // protocol violations seen by the bound assertions
    fail_count = fail_count + int'(uut.u_props.violations);
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog, sized from the transaction count
  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/rv32m_props.sv ====
/* RV32M handshake properties
   four-phase req/ack rules and result stability at the unit boundary */
`timescale 1ns/1ps
`default_nettype none

module rv32m_props
  import rv32m_pkg::*;
(
  input wire        CLK,
  input wire        nRST,
  input wire        req,
  input wire        ack,
  input wire word_t result
);

  // count of failed properties
  int unsigned violations = 0;

  // ack only answers a live request
  ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(ack) |-> $past(req))
  else begin
    $error("ack rose while req was low");
    violations++;
  end

  // req may only fall once ack is up
  req_held: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(req) |-> ack)
  else begin
    $error("req dropped before ack");
    violations++;
  end

  // result frozen for the whole ack phase
  result_stable: assert property (@(posedge CLK) disable iff (!nRST)
    ack && $past(ack) |-> $stable(result))
  else begin
    $error("result changed while ack was high");
    violations++;
  end

  // ack drops on the clock after req is seen low
  ack_release: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(req) |=> !ack)
  else begin
    $error("ack still high after req fell");
    violations++;
  end

endmodule

bind rv32m_unit rv32m_props u_props (
  .CLK    (CLK),
  .nRST   (nRST),
  .req    (req),
  .ack    (ack),
  .result (result)
);

`default_nettype wire

// ==== hdl/rv32m_unit.sv ====
/* RV32M multiply/divide unit
   execute controller joined to the shift-add multiplier and the divider */
`timescale 1ns/1ps
`default_nettype none

module rv32m_unit
  import rv32m_pkg::*;
(
  input  wire         CLK,
  input  wire         nRST,
  input  wire         req,
  input  wire [2:0]   funct3,
  input  wire word_t  rs1_data,
  input  wire word_t  rs2_data,
  output logic        ack,
  output word_t       result
);

  // controller to multiplier
  logic       mul_start;
  logic       mul_finished;
  word_t      mul_a;
  word_t      mul_b;
  sign_mode_t mul_sign;
  dword_t     mul_product;

  // controller to divider
  logic  div_start;
  logic  div_finished;
  logic  div_signed;
  word_t div_a;
  word_t div_b;
  word_t div_quotient;
  word_t div_remainder;

  rv32m_execute u_execute (
    .CLK           (CLK),
    .nRST          (nRST),
    .req           (req),
    .funct3        (funct3),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .ack           (ack),
    .result        (result),
    .mul_start     (mul_start),
    .mul_a         (mul_a),
    .mul_b         (mul_b),
    .mul_sign      (mul_sign),
    .mul_finished  (mul_finished),
    .mul_product   (mul_product),
    .div_start     (div_start),
    .div_a         (div_a),
    .div_b         (div_b),
    .div_signed    (div_signed),
    .div_finished  (div_finished),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder)
  );

  shift_add_multiplier u_mult (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (mul_start),
    .multiplicand (mul_a),
    .multiplier   (mul_b),
    .is_signed    (mul_sign),
    .finished     (mul_finished),
    .product      (mul_product)
  );

  radix2_divider u_div (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (div_start),
    .dividend  (div_a),
    .divisor   (div_b),
    .is_signed (div_signed),
    .finished  (div_finished),
    .quotient  (div_quotient),
    .remainder (div_remainder)
  );

endmodule

`default_nettype wire

// ==== hdl/rv32m_execute.sv ====
/* RV32M execute controller
   four-phase request handling, per-unit operand saver with result reuse,
   dispatch to multiplier or divider and registered result select */
`timescale 1ns/1ps
`default_nettype none

`include "rv32m_params.svh"

module rv32m_execute
  import rv32m_pkg::*;
(
  input  wire              CLK,
  input  wire              nRST,
  input  wire              req,
  input  wire rv32m_op_u   funct3,
  input  wire word_t       rs1_data,
  input  wire word_t       rs2_data,
  output logic             ack,
  output word_t            result,
  output logic             mul_start,
  output word_t            mul_a,
  output word_t            mul_b,
  output sign_mode_t       mul_sign,
  input  wire              mul_finished,
  input  wire dword_t      mul_product,
  output logic             div_start,
  output word_t            div_a,
  output word_t            div_b,
  output logic             div_signed,
  input  wire              div_finished,
  input  wire word_t       div_quotient,
  input  wire word_t       div_remainder
);

  localparam int W = `RV32M_WORD;

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_WAIT    = 2'd1;
  localparam logic [1:0] ST_ANSWER  = 2'd2;
  localparam logic [1:0] ST_RELEASE = 2'd3;

  logic [1:0] state;

  // decoded request
  logic       is_div;
  sign_mode_t sign_curr;
  logic       signed_curr;

  // saved results, operands live in the unit-side outputs
  logic   mul_valid;
  logic   div_valid;
  dword_t mul_prod_save;
  word_t  div_quo_save;
  word_t  div_rem_save;

  logic  mul_match;
  logic  div_match;
  logic  hit;
  logic  dispatch;
  word_t res_sel;

  assign is_div      = funct3.mul_view.div_sel;
  assign signed_curr = ~funct3.div_view.is_unsigned;

  // low product half is the same in any mode, so MUL shares MULH's mode
  always_comb begin
    case (funct3.mul_view.kind)
      MUL_LOW, MUL_HSS: sign_curr = 2'b11;
      MUL_HSU:          sign_curr = 2'b10;
      MUL_HUU:          sign_curr = 2'b00;
      default:          sign_curr = 2'b11;
    endcase
  end

  // exact operand and mode match on the unit the opcode targets
  assign mul_match = mul_valid && (mul_a == rs1_data) && (mul_b == rs2_data) &&
                     (mul_sign == sign_curr);
  assign div_match = div_valid && (div_a == rs1_data) && (div_b == rs2_data) &&
                     (div_signed == signed_curr);
  assign hit       = is_div ? div_match : mul_match;
  assign dispatch  = (state == ST_IDLE) && req && !hit;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= ST_IDLE;
      ack       <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
      mul_valid <= 1'b0;
      div_valid <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      div_start <= 1'b0;
      if (mul_finished) begin
        mul_valid <= 1'b1;
      end
      if (div_finished) begin
        div_valid <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (req && hit) begin
            state <= ST_ANSWER;
          end else if (dispatch) begin
            state <= ST_WAIT;
            // saved copy is stale until the unit finishes
            if (is_div) begin
              div_start <= 1'b1;
              div_valid <= 1'b0;
            end else begin
              mul_start <= 1'b1;
              mul_valid <= 1'b0;
            end
          end
        end
        ST_WAIT: begin
          if (is_div ? div_finished : mul_finished) begin
            state <= ST_ANSWER;
          end
        end
        ST_ANSWER: begin
          ack   <= 1'b1;
          state <= ST_RELEASE;
        end
        ST_RELEASE: begin
          // drop ack once req is seen low
          if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // product half, or quotient or remainder
  always_comb begin
    if (is_div) begin
      res_sel = funct3.div_view.rem_sel ? div_rem_save : div_quo_save;
    end else if (funct3.mul_view.kind == MUL_LOW) begin
      res_sel = mul_prod_save[W-1:0];
    end else begin
      res_sel = mul_prod_save[2*W-1:W];
    end
  end

  always_ff @(posedge CLK) begin
    if (dispatch) begin
      if (is_div) begin
        div_a      <= rs1_data;
        div_b      <= rs2_data;
        div_signed <= signed_curr;
      end else begin
        mul_a    <= rs1_data;
        mul_b    <= rs2_data;
        mul_sign <= sign_curr;
      end
    end
    if (mul_finished) begin
      mul_prod_save <= mul_product;
    end
    if (div_finished) begin
      div_quo_save <= div_quotient;
      div_rem_save <= div_remainder;
    end
    // result loads with ack and holds through release
    if (state == ST_ANSWER) begin
      result <= res_sel;
    end
  end

endmodule

`default_nettype wire

// ==== divider/radix2_divider.sv ====
/* radix-2 restoring divider
   one quotient bit per cycle on magnitudes, then sign fix-up;
   zero divisor and signed overflow answered in the first cycle */
`timescale 1ns/1ps
`default_nettype none

`include "rv32m_params.svh"

module radix2_divider
  import rv32m_pkg::*;
(
  input  wire         CLK,
  input  wire         nRST,
  input  wire         start,
  input  wire word_t  dividend,
  input  wire word_t  divisor,
  input  wire         is_signed,
  output logic        finished,
  output word_t       quotient,
  output word_t       remainder
);

  localparam int W  = `RV32M_WORD;
  localparam int CW = $clog2(`RV32M_DIV_STEPS);

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_RUN  = 2'd1;
  localparam logic [1:0] PH_FIX  = 2'd2;

  logic [1:0]    phase;
  logic [CW-1:0] step;

  // partial remainder, quotient shifting in from the right
  word_t rem;
  word_t quo;
  word_t dvsr;
  logic  q_neg;
  logic  r_neg;

  logic  a_neg;
  logic  b_neg;
  word_t a_mag;
  word_t b_mag;
  logic  div_zero;
  logic  overflow;

  // trial subtract, one bit wider than the word
  logic [W:0] shifted;
  logic [W:0] trial;

  assign a_neg    = is_signed & dividend[W-1];
  assign b_neg    = is_signed & divisor[W-1];
  assign a_mag    = a_neg ? -dividend : dividend;
  assign b_mag    = b_neg ? -divisor : divisor;
  assign div_zero = (divisor == '0);
  // most negative value over minus one
  assign overflow = is_signed && (dividend == {1'b1, {(W-1){1'b0}}}) && (divisor == '1);

  assign shifted = {rem, quo[W-1]};
  assign trial   = shifted - {1'b0, dvsr};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      phase    <= PH_IDLE;
      step     <= '0;
      finished <= 1'b0;
    end else begin
      finished <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (start) begin
            if (div_zero || overflow) begin
              finished <= 1'b1;
            end else begin
              phase <= PH_RUN;
              step  <= '0;
            end
          end
        end
        PH_RUN: begin
          step <= step + 1'b1;
          if (step == CW'(`RV32M_DIV_STEPS - 1)) begin
            phase <= PH_FIX;
          end
        end
        PH_FIX: begin
          finished <= 1'b1;
          phase    <= PH_IDLE;
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (phase == PH_IDLE && start) begin
      // special cases go straight to the outputs
      if (div_zero) begin
        quotient  <= '1;
        remainder <= dividend;
      end else if (overflow) begin
        quotient  <= dividend;
        remainder <= '0;
      end
      rem   <= '0;
      quo   <= a_mag;
      dvsr  <= b_mag;
      q_neg <= a_neg ^ b_neg;
      r_neg <= a_neg;
    end else if (phase == PH_RUN) begin
      if (!trial[W]) begin
        rem <= trial[W-1:0];
        quo <= {quo[W-2:0], 1'b1};
      end else begin
        // restore, keep the shifted remainder
        rem <= shifted[W-1:0];
        quo <= {quo[W-2:0], 1'b0};
      end
    end else if (phase == PH_FIX) begin
      // remainder follows the dividend sign
      quotient  <= q_neg ? -quo : quo;
      remainder <= r_neg ? -rem : rem;
    end
  end

endmodule

`default_nettype wire

// ==== multiplier/shift_add_multiplier.sv ====
/* shift-add multiplier
   multiplies magnitudes one bit per cycle and restores the sign,
   full double-word product valid while finished is high */
`timescale 1ns/1ps
`default_nettype none

`include "rv32m_params.svh"

module shift_add_multiplier
  import rv32m_pkg::*;
(
  input  wire              CLK,
  input  wire              nRST,
  input  wire              start,
  input  wire word_t       multiplicand,
  input  wire word_t       multiplier,
  input  wire sign_mode_t  is_signed,
  output logic             finished,
  output dword_t           product
);

  localparam int W  = `RV32M_WORD;
  localparam int CW = $clog2(`RV32M_MUL_STEPS);

  logic          busy;
  logic [CW-1:0] step;

  // running sum, shifted multiplicand, remaining multiplier bits
  dword_t acc;
  dword_t mcand;
  word_t  mplier;
  logic   negate;

  // operand signs only count in a signed mode
  logic  a_neg;
  logic  b_neg;
  word_t a_mag;
  word_t b_mag;

  assign a_neg = is_signed[SIGN_A] & multiplicand[W-1];
  assign b_neg = is_signed[SIGN_B] & multiplier[W-1];
  assign a_mag = a_neg ? -multiplicand : multiplicand;
  assign b_mag = b_neg ? -multiplier : multiplier;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      step     <= '0;
      finished <= 1'b0;
    end else begin
      finished <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        // last partial product lands this cycle
        if (step == CW'(`RV32M_MUL_STEPS - 1)) begin
          busy     <= 1'b0;
          finished <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      acc    <= '0;
      mcand  <= {{W{1'b0}}, a_mag};
      mplier <= b_mag;
      negate <= a_neg ^ b_neg;
    end else if (busy) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // sign fix-up over the whole double word
  assign product = negate ? -acc : acc;

endmodule

`default_nettype wire

// ==== common/rv32m_pkg.sv ====
/* RV32M shared types
   data words, the funct3 decode union and the multiplier sign mode */
`default_nettype none

`include "rv32m_params.svh"

package rv32m_pkg;

  // one data word and a full product
  typedef logic [`RV32M_WORD-1:0]   word_t;
  typedef logic [2*`RV32M_WORD-1:0] dword_t;

  // bit 1 marks operand A as signed, bit 0 marks operand B
  typedef logic [1:0] sign_mode_t;
  localparam int SIGN_A = 1;
  localparam int SIGN_B = 0;

  // multiply kinds, low two funct3 bits
  localparam logic [1:0] MUL_LOW = 2'b00;
  localparam logic [1:0] MUL_HSS = 2'b01;
  localparam logic [1:0] MUL_HSU = 2'b10;
  localparam logic [1:0] MUL_HUU = 2'b11;

  // funct3 seen as a multiply or as a divide
  typedef union packed {
    struct packed {
      logic       div_sel;
      logic [1:0] kind;
    } mul_view;
    struct packed {
      logic div_sel;
      logic rem_sel;
      logic is_unsigned;
    } div_view;
  } rv32m_op_u;

endpackage

`default_nettype wire

// ==== common/rv32m_params.svh ====
/* RV32M execute parameters
   data word width and iteration counts of the arithmetic units */
`ifndef RV32M_PARAMS_SVH
`define RV32M_PARAMS_SVH

// data word width in bits
`define RV32M_WORD 32

// one iteration per operand bit
`define RV32M_MUL_STEPS 32
`define RV32M_DIV_STEPS 32

`endif
